// File: rtl/bi_params.svh
// sizes assume a 32-bit word over a 37-line bus; the segment widths must still add up to 32
`ifndef BI_PARAMS_SVH
`define BI_PARAMS_SVH

// payload width
`define BI_DATA_W 32

// segments, one invert flag each
`define BI_N_SEG 5

// data plus flags on the wire
`define BI_BUS_W (`BI_DATA_W + `BI_N_SEG)

// leftover lines go to the first segments, which grow one bit wider
`define BI_N_WIDE (`BI_BUS_W % `BI_N_SEG)
`define BI_SEG_WIDE_W 7
`define BI_SEG_NARROW_W 6

// toggle histogram, counts 0..20
// at most 3 data lines plus the flag toggle per segment
`define BI_HIST_BINS 21
`define BI_CNT_W 11
`define BI_BIN_IDX_W 5

// index times count summed over all bins
`define BI_SUM_W 22

`endif

// File: rtl/link_pkg.sv
// link word layout is fixed: payload in the upper 32 bits, invert flags in the lower 5
`include "bi_params.svh"

package link_pkg;

    // raw data word as seen on both ends of the link
    typedef logic [`BI_DATA_W-1:0] data_word_t;

    // word on the bus
    // flag bit i covers segment i, segment 0 starts at payload bit 0
    typedef struct packed {
        data_word_t           data;
        logic [`BI_N_SEG-1:0] inv;
    } link_word_t;

endpackage

// File: rtl/stats_pkg.sv
// report fields are sized for 21 bins of 11-bit counts; the weighted sum cannot wrap at that size
`include "bi_params.svh"

package stats_pkg;

    // one histogram bin, saturating
    typedef logic [`BI_CNT_W-1:0] bin_count_t;

    // result of one report scan
    typedef struct packed {
        logic [`BI_BIN_IDX_W-1:0] max_bin;
        logic [`BI_SUM_W-1:0]     weighted_sum;
    } stats_report_t;

    // report scan FSM
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DONE
    } scan_state_e;

endpackage

// File: rtl/bi_seg_encoder.sv
// one segment only; state advances on en_i alone, and the tie hold applies to even widths only
module bi_seg_encoder #(
    parameter int SEG_W = 6
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en_i,
    input  logic [SEG_W-1:0] seg_i,
    output logic [SEG_W-1:0] seg_o,
    output logic             inv_o
);

    localparam int DIFF_W = $clog2(SEG_W + 1);
    localparam int HALF = SEG_W / 2;
    // odd widths can never hit an exact half
    localparam bit TIE_HOLD = (SEG_W % 2 == 0);

    logic [SEG_W-1:0]  diff;
    logic [DIFF_W-1:0] diff_cnt;
    logic              inv_next;

    // compare against what is on the wire now, not the raw data
    assign diff = seg_i ^ seg_o;

    // popcount of differing lines
    always_comb begin
        diff_cnt = '0;
        for (int b = 0; b < SEG_W; b++) begin
            diff_cnt = diff_cnt + DIFF_W'(diff[b]);
        end
    end

    // invert on majority
    // exact half keeps the old flag so the flag line stays quiet
    assign inv_next = (diff_cnt > HALF) || (TIE_HOLD && (diff_cnt == HALF) && inv_o);

    // registered segment doubles as the previous value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_o <= '0;
            inv_o <= 1'b0;
        end else if (en_i) begin
            seg_o <= inv_next ? ~seg_i : seg_i;
            inv_o <= inv_next;
        end
    end

endmodule

// File: rtl/bi_encoder.sv
// one cycle latency, no back-pressure; link_o holds its last word between valid strobes
`include "bi_params.svh"

module bi_encoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid_i,
    input  link_pkg::data_word_t data_i,
    output link_pkg::link_word_t link_o,
    output logic                 link_valid_o
);

    localparam int N_WIDE = `BI_N_WIDE;
    localparam int N_NARROW = `BI_N_SEG - `BI_N_WIDE;
    localparam int WIDE_W = `BI_SEG_WIDE_W;
    localparam int NARROW_W = `BI_SEG_NARROW_W;
    // narrow segments start after the wide ones
    localparam int NARROW_BASE = N_WIDE * WIDE_W;

    wire [`BI_DATA_W-1:0] enc_data;
    wire [`BI_N_SEG-1:0]  enc_inv;

    // wide segments from bit 0 upward
    for (genvar i = 0; i < N_WIDE; i++) begin : g_wide
        bi_seg_encoder #(.SEG_W(WIDE_W)) u_seg (
            .clk   (clk),
            .rst_n (rst_n),
            .en_i  (in_valid_i),
            .seg_i (data_i[i*WIDE_W +: WIDE_W]),
            .seg_o (enc_data[i*WIDE_W +: WIDE_W]),
            .inv_o (enc_inv[i])
        );
    end

    // narrow segments, flags follow the wide ones
    for (genvar j = 0; j < N_NARROW; j++) begin : g_narrow
        bi_seg_encoder #(.SEG_W(NARROW_W)) u_seg (
            .clk   (clk),
            .rst_n (rst_n),
            .en_i  (in_valid_i),
            .seg_i (data_i[NARROW_BASE + j*NARROW_W +: NARROW_W]),
            .seg_o (enc_data[NARROW_BASE + j*NARROW_W +: NARROW_W]),
            .inv_o (enc_inv[N_WIDE + j])
        );
    end

    // segment registers already sit on the wire
    assign link_o = '{data: enc_data, inv: enc_inv};

    // valid lines up with the segment registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_valid_o <= 1'b0;
        end else begin
            link_valid_o <= in_valid_i;
        end
    end

endmodule

// File: rtl/bi_decoder.sv
// segment layout must match bi_encoder; data_o keeps the last restored word until the next valid
`include "bi_params.svh"

module bi_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  link_pkg::link_word_t link_i,
    input  logic                 link_valid_i,
    output link_pkg::data_word_t data_o,
    output logic                 out_valid_o
);

    localparam int N_WIDE = `BI_N_WIDE;
    localparam int N_NARROW = `BI_N_SEG - `BI_N_WIDE;
    localparam int WIDE_W = `BI_SEG_WIDE_W;
    localparam int NARROW_W = `BI_SEG_NARROW_W;
    localparam int NARROW_BASE = N_WIDE * WIDE_W;

    wire [`BI_DATA_W-1:0] restored;

    // flip back every flagged segment
    for (genvar i = 0; i < N_WIDE; i++) begin : g_wide
        assign restored[i*WIDE_W +: WIDE_W] =
            link_i.data[i*WIDE_W +: WIDE_W] ^ {WIDE_W{link_i.inv[i]}};
    end

    for (genvar j = 0; j < N_NARROW; j++) begin : g_narrow
        assign restored[NARROW_BASE + j*NARROW_W +: NARROW_W] =
            link_i.data[NARROW_BASE + j*NARROW_W +: NARROW_W] ^ {NARROW_W{link_i.inv[N_WIDE + j]}};
    end

    // one register stage behind the link
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_o      <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= link_valid_i;
            if (link_valid_i) begin
                data_o <= restored;
            end
        end
    end

endmodule

// File: rtl/transition_stats.sv
// bins saturate at 2047 and clear only on reset; requests during a scan are dropped
`include "bi_params.svh"

module transition_stats (
    input  logic                     clk,
    input  logic                     rst_n,
    input  link_pkg::link_word_t     link_i,
    input  logic                     link_valid_i,
    input  logic                     report_req_i,
    output stats_pkg::stats_report_t report_o,
    output logic                     report_valid_o
);

    localparam int BUS_W = `BI_BUS_W;
    localparam int BINS = `BI_HIST_BINS;
    localparam int TGL_W = $clog2(BUS_W + 1);
    localparam int IDX_W = `BI_BIN_IDX_W;
    localparam int SUM_W = `BI_SUM_W;

    link_pkg::link_word_t  prev_q;
    logic [BUS_W-1:0]      toggles;
    logic [TGL_W-1:0]      tgl_cnt;
    logic [IDX_W-1:0]      bin_idx;
    stats_pkg::bin_count_t bins_q [BINS];

    stats_pkg::scan_state_e state_q;
    logic [IDX_W-1:0]       scan_idx_q;
    stats_pkg::bin_count_t  scan_cnt;
    stats_pkg::bin_count_t  run_max_q;
    logic [IDX_W-1:0]       max_idx_q;
    logic [SUM_W-1:0]       run_sum_q;

    // lines that changed since the last transfer, flags included
    assign toggles = link_i ^ prev_q;

    always_comb begin
        tgl_cnt = '0;
        for (int b = 0; b < BUS_W; b++) begin
            tgl_cnt = tgl_cnt + TGL_W'(toggles[b]);
        end
    end

    // encoding keeps this at 20 or below
    // clamp anyway so the bin index stays in range
    assign bin_idx = (tgl_cnt > TGL_W'(BINS - 1)) ? IDX_W'(BINS - 1) : IDX_W'(tgl_cnt);

    // histogram update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_q <= '0;
            for (int b = 0; b < BINS; b++) begin
                bins_q[b] <= '0;
            end
        end else if (link_valid_i) begin
            prev_q <= link_i;
            // hold at full scale
            if (bins_q[bin_idx] != '1) begin
                bins_q[bin_idx] <= bins_q[bin_idx] + 1'b1;
            end
        end
    end

    // bin under the scan pointer
    assign scan_cnt = bins_q[scan_idx_q];

    // report scan, one bin per cycle
    // enter 1, bins 21, result 1 -> valid 23 cycles after request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= stats_pkg::SCAN_IDLE;
            scan_idx_q     <= '0;
            run_max_q      <= '0;
            max_idx_q      <= '0;
            run_sum_q      <= '0;
            report_o       <= '0;
            report_valid_o <= 1'b0;
        end else begin
            report_valid_o <= 1'b0;
            unique case (state_q)
                stats_pkg::SCAN_IDLE: begin
                    if (report_req_i) begin
                        state_q    <= stats_pkg::SCAN_RUN;
                        scan_idx_q <= '0;
                        run_max_q  <= '0;
                        max_idx_q  <= '0;
                        run_sum_q  <= '0;
                    end
                end
                stats_pkg::SCAN_RUN: begin
                    // strict compare, earlier index wins a tie
                    if (scan_cnt > run_max_q) begin
                        run_max_q <= scan_cnt;
                        max_idx_q <= scan_idx_q;
                    end
                    run_sum_q <= run_sum_q + SUM_W'(scan_idx_q) * SUM_W'(scan_cnt);
                    if (scan_idx_q == IDX_W'(BINS - 1)) begin
                        state_q <= stats_pkg::SCAN_DONE;
                    end else begin
                        scan_idx_q <= scan_idx_q + 1'b1;
                    end
                end
                stats_pkg::SCAN_DONE: begin
                    report_o       <= '{max_bin: max_idx_q, weighted_sum: run_sum_q};
                    report_valid_o <= 1'b1;
                    state_q        <= stats_pkg::SCAN_IDLE;
                end
                default: begin
                    state_q <= stats_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/bi_link_top.sv
// link word 1 cycle and decoded word 2 cycles after in_valid_i; report 23 cycles after request
module bi_link_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid_i,
    input  link_pkg::data_word_t     data_i,
    input  logic                     report_req_i,
    output link_pkg::link_word_t     link_o,
    output logic                     link_valid_o,
    output link_pkg::data_word_t     data_o,
    output logic                     out_valid_o,
    output stats_pkg::stats_report_t report_o,
    output logic                     report_valid_o
);

    // transmit side
    bi_encoder u_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .data_i       (data_i),
        .link_o       (link_o),
        .link_valid_o (link_valid_o)
    );

    // receive side, straight off the bus
    bi_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .link_i       (link_o),
        .link_valid_i (link_valid_o),
        .data_o       (data_o),
        .out_valid_o  (out_valid_o)
    );

    // watches the same bus word in parallel
    // results go straight out, nothing merges them with the decoder
    transition_stats u_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .link_i         (link_o),
        .link_valid_i   (link_valid_o),
        .report_req_i   (report_req_i),
        .report_o       (report_o),
        .report_valid_o (report_valid_o)
    );

endmodule

// File: tb/bi_link_chk.sv
// bound to bi_link_top; assumes the 7/7/6/6/6 segment layout and a 21-bin report scan
`include "bi_params.svh"

module bi_link_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid_i,
    input logic                 report_req_i,
    input link_pkg::link_word_t link_i,
    input logic                 link_valid_i,
    input logic                 out_valid_i,
    input logic                 report_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // enter, one cycle per bin, register result
    localparam int SCAN_LAT = `BI_HIST_BINS + 2;
    // 3 data lines plus the flag
    localparam int MAX_SEG_TGL = 4;

    link_pkg::link_word_t prev_link_q;
    logic [4:0]           busy_cnt_q;
    logic                 req_accepted;
    logic                 seg_bound_ok;

    // mirror of the scan window, requests inside it are dropped
    assign req_accepted = report_req_i && (busy_cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt_q <= '0;
        end else if (req_accepted) begin
            busy_cnt_q <= 5'(SCAN_LAT - 1);
        end else if (busy_cnt_q != '0) begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
        end
    end

    // bus word of the last transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_link_q <= '0;
        end else if (link_valid_i) begin
            prev_link_q <= link_i;
        end
    end

    // toggled lines per segment, flag included
    always_comb begin
        int lsb;
        int w;
        int cnt;
        seg_bound_ok = 1'b1;
        lsb = 0;
        for (int s = 0; s < `BI_N_SEG; s++) begin
            w = (s < `BI_N_WIDE) ? `BI_SEG_WIDE_W : `BI_SEG_NARROW_W;
            cnt = int'(link_i.inv[s] != prev_link_q.inv[s]);
            for (int b = 0; b < w; b++) begin
                cnt += int'(link_i.data[lsb + b] != prev_link_q.data[lsb + b]);
            end
            if (cnt > MAX_SEG_TGL) begin
                seg_bound_ok = 1'b0;
            end
            lsb += w;
        end
    end

    a_out_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_i |-> ##2 out_valid_i)
        else $error("out_valid_o missing 2 cycles after in_valid_i");

    a_out_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_i |-> $past(in_valid_i, 2))
        else $error("out_valid_o without in_valid_i 2 cycles before");

    a_report_lat: assert property (@(posedge clk) disable iff (!rst_n)
        req_accepted |-> ##SCAN_LAT report_valid_i)
        else $error("report_valid_o missing after accepted report request");

    a_report_src: assert property (@(posedge clk) disable iff (!rst_n)
        report_valid_i |-> $past(req_accepted, SCAN_LAT))
        else $error("report_valid_o without a matching report request");

    a_seg_bound: assert property (@(posedge clk) disable iff (!rst_n)
        link_valid_i |-> seg_bound_ok)
        else $error("a link segment toggled more than 4 lines");

endmodule

bind bi_link_top bi_link_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid_i),
    .report_req_i   (report_req_i),
    .link_i         (link_o),
    .link_valid_i   (link_valid_o),
    .out_valid_i    (out_valid_o),
    .report_valid_i (report_valid_o)
);

// File: tb/bi_link_tb.sv
// rows go out back to back; the report is requested only once the link has gone idle
`include "bi_params.svh"

module bi_link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_FIXED = 16;
    localparam int N_ROWS = N_FIXED + 48;
    localparam int RESET_CYCLES = 4;
    localparam int REPORT_LAT = `BI_HIST_BINS + 2;
    // reset, rows, decode pipeline, report scan, margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ROWS + 2 + REPORT_LAT + 40;
    localparam int BIN_MAX = (1 << `BI_CNT_W) - 1;
    localparam int T_RESET = 0;
    localparam int T_ENC = 1;
    localparam int T_RT = 2;
    localparam int T_TIE = 3;
    localparam int T_REP = 4;
    localparam logic [31:0] SEED = 32'hab61_b687;

    // edge cases are extremes, alternation, narrow-segment ties and single-bit steps
    localparam link_pkg::data_word_t FIXED_ROWS [N_FIXED] = '{
        32'h0000_0000, 32'hffff_ffff, 32'haaaa_aaaa, 32'h5555_5555,
        32'h0000_0000, 32'h0000_0001, 32'h0000_0003, 32'h8000_0000,
        32'h0001_c000, 32'h0fff_f000, 32'hf0f0_f0f0, 32'h0f0f_0f0f,
        32'h1234_5678, 32'hdead_beef, 32'hffff_ffff, 32'h0000_0000
    };

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid_i;
    link_pkg::data_word_t     data_i;
    logic                     report_req_i;
    link_pkg::link_word_t     link_o;
    logic                     link_valid_o;
    link_pkg::data_word_t     data_o;
    logic                     out_valid_o;
    stats_pkg::stats_report_t report_o;
    logic                     report_valid_o;

    // stimulus and expected values
    link_pkg::data_word_t stim [N_ROWS];
    link_pkg::link_word_t exp_link [N_ROWS];
    logic [`BI_N_SEG-1:0] tie_mask [N_ROWS];
    // model flags of the word before each row
    logic [`BI_N_SEG-1:0] prev_inv [N_ROWS];
    int                   exp_max_bin;
    longint               exp_sum;
    int                   tie_one_rows;

    int                       cycle;
    int                       link_cnt;
    int                       out_cnt;
    int                       req_cycle;
    int                       rep_cycle;
    bit                       rep_seen;
    stats_pkg::stats_report_t rep_val;
    int                       checks [5];
    int                       errors [5];
    string                    test_names [5] = '{"reset", "encoding", "round trip",
                                                 "tie hold", "statistics report"};

    bi_link_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid_i),
        .data_i         (data_i),
        .report_req_i   (report_req_i),
        .link_o         (link_o),
        .link_valid_o   (link_valid_o),
        .data_o         (data_o),
        .out_valid_o    (out_valid_o),
        .report_o       (report_o),
        .report_valid_o (report_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int seg_width(input int s);
        return (s < `BI_N_WIDE) ? `BI_SEG_WIDE_W : `BI_SEG_NARROW_W;
    endfunction

    // majority against the previous bus value
    // exact half holds the old flag
    function automatic link_pkg::link_word_t encode_word(input link_pkg::data_word_t d,
            input link_pkg::link_word_t prev, output logic [`BI_N_SEG-1:0] ties);
        link_pkg::link_word_t enc;
        int lsb;
        int w;
        int diff;
        logic flip;
        lsb = 0;
        ties = '0;
        for (int s = 0; s < `BI_N_SEG; s++) begin
            w = seg_width(s);
            diff = 0;
            for (int b = 0; b < w; b++) begin
                diff += int'(d[lsb + b] != prev.data[lsb + b]);
            end
            flip = (2 * diff > w);
            if (2 * diff == w) begin
                flip = prev.inv[s];
                ties[s] = 1'b1;
            end
            for (int b = 0; b < w; b++) begin
                enc.data[lsb + b] = d[lsb + b] ^ flip;
            end
            enc.inv[s] = flip;
            lsb += w;
        end
        return enc;
    endfunction

    function automatic int count_toggles(input link_pkg::link_word_t a,
            input link_pkg::link_word_t b);
        int n;
        n = 0;
        for (int i = 0; i < `BI_BUS_W; i++) begin
            n += int'(a[i] != b[i]);
        end
        return n;
    endfunction

    // fill rows, expected bus words, histogram and report
    task automatic build_table();
        logic [31:0]          lfsr;
        link_pkg::link_word_t prev;
        logic [`BI_N_SEG-1:0] ties;
        int                   hist [`BI_HIST_BINS];
        int                   best;
        int                   tgl;
        lfsr = SEED;
        for (int r = 0; r < N_ROWS; r++) begin
            stim[r] = (r < N_FIXED) ? FIXED_ROWS[r] : '0;
            // one step per bit taken
            for (int b = 0; b < `BI_DATA_W && r >= N_FIXED; b++) begin
                lfsr = lfsr_step(lfsr);
                stim[r] = {stim[r][`BI_DATA_W-2:0], lfsr[0]};
            end
        end
        prev = '0;
        tie_one_rows = 0;
        foreach (hist[i]) hist[i] = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            exp_link[r] = encode_word(stim[r], prev, ties);
            tie_mask[r] = ties;
            prev_inv[r] = prev.inv;
            tie_one_rows += int'(|(ties & prev.inv));
            tgl = count_toggles(exp_link[r], prev);
            if (hist[tgl] < BIN_MAX) hist[tgl]++;
            prev = exp_link[r];
        end
        // lowest index wins among equal counts
        best = 0;
        exp_max_bin = 0;
        exp_sum = 0;
        for (int i = 0; i < `BI_HIST_BINS; i++) begin
            if (hist[i] > best) begin
                best = hist[i];
                exp_max_bin = i;
            end
            exp_sum += longint'(i) * hist[i];
        end
    endtask

    task automatic check_value(input int test, input string name,
            input logic [63:0] exp, input logic [63:0] act);
        checks[test]++;
        if (act !== exp) begin
            errors[test]++;
            $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input int test, input string what);
        errors[test]++;
        $display("test %s: %s", test_names[test], what);
    endtask

    task automatic finish_test(input int test);
        if (errors[test] == 0) begin
            $display("test %s: ok, %0d checks", test_names[test], checks[test]);
        end else begin
            $display("test %s: failed, %0d errors in %0d checks", test_names[test],
                     errors[test], checks[test]);
        end
    endtask

    // outputs sampled mid-cycle well away from the rising edge
    always @(negedge clk) begin
        if (rst_n && link_valid_o) begin
            if (link_cnt < N_ROWS) begin
                check_value(T_ENC, "link_o", exp_link[link_cnt], link_o);
                for (int s = 0; s < `BI_N_SEG; s++) begin
                    if (tie_mask[link_cnt][s]) begin
                        check_value(T_TIE, $sformatf("link_o.inv[%0d]", s),
                                    prev_inv[link_cnt][s], link_o.inv[s]);
                    end
                end
            end else begin
                report_failure(T_ENC, "link_valid_o pulsed more often than words were sent");
            end
            link_cnt++;
        end
        if (rst_n && out_valid_o) begin
            if (out_cnt < N_ROWS) begin
                check_value(T_RT, "data_o", stim[out_cnt], data_o);
            end else begin
                report_failure(T_RT, "out_valid_o pulsed more often than words were sent");
            end
            out_cnt++;
        end
        if (rst_n && report_valid_o) begin
            rep_seen = 1'b1;
            rep_cycle = cycle;
            rep_val = report_o;
        end
    end

    initial begin : watchdog
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errors;
        rst_n = 1'b0;
        in_valid_i = 1'b0;
        data_i = '0;
        report_req_i = 1'b0;
        link_cnt = 0;
        out_cnt = 0;
        rep_seen = 1'b0;
        foreach (checks[t]) checks[t] = 0;
        foreach (errors[t]) errors[t] = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(T_RESET, "link_valid_o", '0, link_valid_o);
        check_value(T_RESET, "out_valid_o", '0, out_valid_o);
        check_value(T_RESET, "report_valid_o", '0, report_valid_o);
        check_value(T_RESET, "link_o", '0, link_o);
        check_value(T_RESET, "data_o", '0, data_o);
        check_value(T_RESET, "report_o", '0, report_o);
        finish_test(T_RESET);
        // one word per cycle with no gaps
        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge clk);
            #10;
            in_valid_i = 1'b1;
            data_i = stim[r];
        end
        @(posedge clk);
        #10;
        in_valid_i = 1'b0;
        data_i = '0;
        wait (out_cnt == N_ROWS);
        if (link_cnt != N_ROWS) report_failure(T_ENC, "link word count differs from rows sent");
        finish_test(T_ENC);
        finish_test(T_RT);
        if (tie_one_rows == 0 || checks[T_TIE] == 0) begin
            report_failure(T_TIE, "no row produced a tie with the previous flag set");
        end
        finish_test(T_TIE);
        @(posedge clk);
        #10;
        report_req_i = 1'b1;
        req_cycle = cycle;
        @(posedge clk);
        #10;
        report_req_i = 1'b0;
        wait (rep_seen);
        check_value(T_REP, "report_valid_o latency", REPORT_LAT, rep_cycle - req_cycle);
        check_value(T_REP, "report_o.max_bin", exp_max_bin, rep_val.max_bin);
        check_value(T_REP, "report_o.weighted_sum", exp_sum, rep_val.weighted_sum);
        finish_test(T_REP);
        total_checks = checks.sum();
        total_errors = errors.sum();
        $display("tests: 5, checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/link_pkg.sv
rtl/stats_pkg.sv
rtl/bi_seg_encoder.sv
rtl/bi_encoder.sv
rtl/bi_decoder.sv
rtl/transition_stats.sv
rtl/bi_link_top.sv
tb/bi_link_chk.sv
tb/bi_link_tb.sv

// File: Bender.yml
package:
  name: bi_link

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/link_pkg.sv
      - rtl/stats_pkg.sv
      - rtl/bi_seg_encoder.sv
      - rtl/bi_encoder.sv
      - rtl/bi_decoder.sv
      - rtl/transition_stats.sv
      - rtl/bi_link_top.sv
  - target: test
    files:
      - tb/bi_link_chk.sv
      - tb/bi_link_tb.sv
